/* filelist.f */
+incdir+include
logic/core_pkg.sv
logic/issue_if.sv
logic/fetch_unit.sv
logic/decode_issue.sv
logic/alu_commit.sv
logic/core_top.sv
verif/tb_core.sv

/* Makefile */
# Verilator build and run of the RV32I core testbench

SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_core
FILELIST = filelist.f
BUILD    = obj_dir
PASS_MSG = sim passed

.PHONY: all compile run clean

all: run

# Build the simulation executable
compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# Run and decide pass or fail from the printed output
run: compile
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

/* verif/tb_core.sv */
// Testbench for the RV32I core: program table, AXI4-Lite read slave model,
// commit checks and a watchdog

`timescale 1ns/10ps

`include "core_macros.svh"

module tb_core import core_pkg::*; ();

    localparam int        CLK_PERIOD      = 40;
    localparam int        NUM_ENTRIES     = 24;
    localparam int        WATCHDOG_CYCLES = NUM_ENTRIES * 12 + 20;
    localparam addr_t     BOOT_ADDR       = 32'h0000_1000;
    localparam axi_resp_t RESP_SLVERR     = 2'b10;

    // One program entry with its expected retirement
    typedef struct packed {
        instr_t    instr;
        logic      we;
        reg_addr_t rd;
        xlen_t     value;
        logic      illegal;
        logic      fault;
    } entry_t;

    logic      clk_i;
    logic      rst_ni;
    logic      fetch_enable_i;
    addr_t     boot_addr_i;
    addr_t     axi_araddr_o;
    logic      axi_arvalid_o;
    logic      axi_arready_i;
    logic      axi_rvalid_i;
    logic      axi_rready_o;
    xlen_t     axi_rdata_i;
    axi_resp_t axi_rresp_i;
    logic      commit_valid_o;
    addr_t     commit_pc_o;
    reg_addr_t commit_rd_o;
    logic      commit_we_o;
    xlen_t     commit_wdata_o;
    logic      commit_illegal_o;
    logic      commit_fault_o;

    entry_t      prog [NUM_ENTRIES];
    int          n_fill = 0;
    int          errors = 0;
    int          checks = 0;
    logic [31:0] lcg_state = 32'd81540;

    core_top dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state >> 16;
    endfunction

    function automatic instr_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                     logic [2:0] f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, `OPC_OP};
    endfunction

    function automatic instr_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                     reg_addr_t rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic instr_t enc_u(logic [19:0] imm, reg_addr_t rd);
        return {imm, rd, `OPC_LUI};
    endfunction

    function automatic void add_entry(instr_t instr, logic we, reg_addr_t rd, xlen_t value,
                                      logic illegal, logic fault);
        prog[n_fill] = '{instr, we, rd, value, illegal, fault};
        n_fill++;
    endfunction

    task automatic check_equal(string what, xlen_t actual, xlen_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // Each call consumes one commit
    task automatic wait_commit();
        @(negedge clk_i);
        while (!commit_valid_o) @(negedge clk_i);
    endtask

    // Expected values worked out by hand from the RV32I rules
    task automatic build_program();
        // Immediate forms and LUI
        add_entry(enc_i(12'h005, 5'd0, `F3_ADD_SUB, 5'd1, `OPC_OP_IMM), 1'b1, 5'd1,
                  32'h0000_0005, 1'b0, 1'b0);
        add_entry(enc_i(12'hFFD, 5'd0, `F3_ADD_SUB, 5'd2, `OPC_OP_IMM), 1'b1, 5'd2,
                  32'hFFFF_FFFD, 1'b0, 1'b0);
        add_entry(enc_u(20'h12345, 5'd3), 1'b1, 5'd3, 32'h1234_5000, 1'b0, 1'b0);
        // Back to back through the bypass
        add_entry(enc_i(12'h678, 5'd3, `F3_OR, 5'd4, `OPC_OP_IMM), 1'b1, 5'd4,
                  32'h1234_5678, 1'b0, 1'b0);
        add_entry(enc_i(12'hFFF, 5'd4, `F3_XOR, 5'd5, `OPC_OP_IMM), 1'b1, 5'd5,
                  32'hEDCB_A987, 1'b0, 1'b0);
        add_entry(enc_i(12'h0F0, 5'd4, `F3_AND, 5'd6, `OPC_OP_IMM), 1'b1, 5'd6,
                  32'h0000_0070, 1'b0, 1'b0);
        add_entry(enc_i(12'hFFE, 5'd2, `F3_SLT, 5'd7, `OPC_OP_IMM), 1'b1, 5'd7,
                  32'h0000_0001, 1'b0, 1'b0);
        add_entry(enc_i(12'h005, 5'd2, `F3_SLTU, 5'd8, `OPC_OP_IMM), 1'b1, 5'd8,
                  32'h0000_0000, 1'b0, 1'b0);
        add_entry(enc_i(12'h004, 5'd1, `F3_SLL, 5'd9, `OPC_OP_IMM), 1'b1, 5'd9,
                  32'h0000_0050, 1'b0, 1'b0);
        add_entry(enc_i(12'h01C, 5'd2, `F3_SRL_SRA, 5'd10, `OPC_OP_IMM), 1'b1, 5'd10,
                  32'h0000_000F, 1'b0, 1'b0);
        add_entry(enc_i(12'h401, 5'd2, `F3_SRL_SRA, 5'd11, `OPC_OP_IMM), 1'b1, 5'd11,
                  32'hFFFF_FFFE, 1'b0, 1'b0);
        // Register forms, negative operands for SLT against SLTU
        add_entry(enc_r(7'b0, 5'd2, 5'd1, `F3_ADD_SUB, 5'd12), 1'b1, 5'd12,
                  32'h0000_0002, 1'b0, 1'b0);
        add_entry(enc_r(`F7_ALT, 5'd2, 5'd1, `F3_ADD_SUB, 5'd13), 1'b1, 5'd13,
                  32'h0000_0008, 1'b0, 1'b0);
        add_entry(enc_r(7'b0, 5'd1, 5'd2, `F3_SLT, 5'd14), 1'b1, 5'd14,
                  32'h0000_0001, 1'b0, 1'b0);
        add_entry(enc_r(7'b0, 5'd1, 5'd2, `F3_SLTU, 5'd15), 1'b1, 5'd15,
                  32'h0000_0000, 1'b0, 1'b0);
        // Shift amount 0x50 keeps only its low 5 bits
        add_entry(enc_r(`F7_ALT, 5'd9, 5'd2, `F3_SRL_SRA, 5'd16), 1'b1, 5'd16,
                  32'hFFFF_FFFF, 1'b0, 1'b0);
        add_entry(enc_r(7'b0, 5'd1, 5'd4, `F3_SRL_SRA, 5'd17), 1'b1, 5'd17,
                  32'h0091_A2B3, 1'b0, 1'b0);
        add_entry(enc_r(7'b0, 5'd10, 5'd1, `F3_SLL, 5'd18), 1'b1, 5'd18,
                  32'h0002_8000, 1'b0, 1'b0);
        // x0 target, then read x0 back
        add_entry(enc_i(12'h007, 5'd1, `F3_ADD_SUB, 5'd0, `OPC_OP_IMM), 1'b0, 5'd0,
                  32'h0000_0000, 1'b0, 1'b0);
        add_entry(enc_r(7'b0, 5'd1, 5'd0, `F3_ADD_SUB, 5'd19), 1'b1, 5'd19,
                  32'h0000_0005, 1'b0, 1'b0);
        // SYSTEM opcode is illegal, the next one returns an error response
        add_entry(enc_i(12'h005, 5'd0, 3'b000, 5'd1, 7'b1110011), 1'b0, 5'd1,
                  32'h0000_0000, 1'b1, 1'b0);
        add_entry(enc_i(12'd99, 5'd0, `F3_ADD_SUB, 5'd1, `OPC_OP_IMM), 1'b0, 5'd1,
                  32'h0000_0000, 1'b0, 1'b1);
        // x1 must still hold 5
        add_entry(enc_r(7'b0, 5'd0, 5'd1, `F3_OR, 5'd20), 1'b1, 5'd20,
                  32'h0000_0005, 1'b0, 1'b0);
        add_entry(enc_r(`F7_ALT, 5'd12, 5'd20, `F3_ADD_SUB, 5'd21), 1'b1, 5'd21,
                  32'h0000_0003, 1'b0, 1'b0);
    endtask

    // --------------------------------------------------
    // AXI4-Lite read slave with random delays
    // --------------------------------------------------
    initial begin : memory_model
        int unsigned delay;
        int          idx;
        axi_arready_i  = 1'b0;
        axi_rvalid_i   = 1'b0;
        axi_rdata_i    = '0;
        axi_rresp_i    = `AXI_RESP_OKAY;
        fetch_enable_i = 1'b0;
        @(posedge rst_ni);
        @(posedge clk_i);
        fetch_enable_i <= 1'b1;
        forever begin
            @(negedge clk_i);
            if (axi_arvalid_o) begin
                delay = next_rand() % 32'd4;
                repeat (delay) @(negedge clk_i);
                @(posedge clk_i);
                axi_arready_i <= 1'b1;
                // Address sampled mid cycle, accepted at the next edge
                @(negedge clk_i);
                idx = int'((axi_araddr_o - BOOT_ADDR) >> 2);
                @(posedge clk_i);
                axi_arready_i <= 1'b0;
                // Last entry requested, stop further fetches
                if (idx == NUM_ENTRIES - 1) begin
                    fetch_enable_i <= 1'b0;
                end
                delay = next_rand() % 32'd4;
                repeat (delay) @(posedge clk_i);
                @(posedge clk_i);
                axi_rvalid_i <= 1'b1;
                if (idx >= 0 && idx < NUM_ENTRIES) begin
                    axi_rdata_i <= prog[idx].instr;
                    axi_rresp_i <= prog[idx].fault ? RESP_SLVERR : `AXI_RESP_OKAY;
                end else begin
                    axi_rdata_i <= '0;
                    axi_rresp_i <= `AXI_RESP_OKAY;
                end
                @(negedge clk_i);
                while (!axi_rready_o) @(negedge clk_i);
                @(posedge clk_i);
                axi_rvalid_i <= 1'b0;
            end
        end
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout after %0d cycles with %0d errors, commits stopped arriving",
                 WATCHDOG_CYCLES, errors);
        $display("sim failed");
        $finish;
    end

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        rst_ni      = 1'b0;
        boot_addr_i = BOOT_ADDR;
        build_program();
        repeat (3) @(posedge clk_i);
        rst_ni <= 1'b1;

        @(negedge clk_i);
        check_equal("arvalid after reset", xlen_t'(axi_arvalid_o), 32'd0);
        check_equal("rready after reset", xlen_t'(axi_rready_o), 32'd0);
        check_equal("commit_valid after reset", xlen_t'(commit_valid_o), 32'd0);
        check_equal("araddr after reset", axi_araddr_o, BOOT_ADDR);

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            wait_commit();
            check_equal($sformatf("entry %0d pc", i), commit_pc_o,
                        BOOT_ADDR + addr_t'(i * 4));
            check_equal($sformatf("entry %0d we", i), xlen_t'(commit_we_o),
                        xlen_t'(prog[i].we));
            check_equal($sformatf("entry %0d illegal", i), xlen_t'(commit_illegal_o),
                        xlen_t'(prog[i].illegal));
            check_equal($sformatf("entry %0d fault", i), xlen_t'(commit_fault_o),
                        xlen_t'(prog[i].fault));
            check_equal($sformatf("entry %0d rd", i), xlen_t'(commit_rd_o),
                        xlen_t'(prog[i].rd));
            if (prog[i].we) begin
                check_equal($sformatf("entry %0d wdata", i), commit_wdata_o,
                            prog[i].value);
            end
        end

        // Fetch is off now, nothing else may retire
        repeat (20) begin
            @(negedge clk_i);
            if (commit_valid_o) begin
                errors++;
                $display("Unexpected commit at %0t after the program ended", $time);
            end
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* logic/core_top.sv */
// Top level of the RV32I core
// Registered fetch enable and the fetch, decode and execute stages

`timescale 1ns/10ps

module core_top import core_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      fetch_enable_i,
    input  addr_t     boot_addr_i,
    // AXI4-Lite instruction read port
    output addr_t     axi_araddr_o,
    output logic      axi_arvalid_o,
    input  logic      axi_arready_i,
    input  logic      axi_rvalid_i,
    output logic      axi_rready_o,
    input  xlen_t     axi_rdata_i,
    input  axi_resp_t axi_rresp_i,
    // Commit port
    output logic      commit_valid_o,
    output addr_t     commit_pc_o,
    output reg_addr_t commit_rd_o,
    output logic      commit_we_o,
    output xlen_t     commit_wdata_o,
    output logic      commit_illegal_o,
    output logic      commit_fault_o
);

    logic      fetch_enable_q;

    // Fetch buffer to decode
    logic      fetch_valid;
    instr_t    fetch_instr;
    addr_t     fetch_pc;
    logic      fetch_fault;
    logic      fetch_ack;

    // Write-back to the register file
    logic      wb_en;
    reg_addr_t wb_rd;
    xlen_t     wb_data;

    issue_if issue ();

    // Only gating left of the controller
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fetch_enable_q <= 1'b0;
        end else begin
            fetch_enable_q <= fetch_enable_i;
        end
    end

    // --------------------------------------------------
    // Pipeline stages
    // --------------------------------------------------
    fetch_unit i_fetch_unit (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .fetch_en_i    (fetch_enable_q),
        .boot_addr_i   (boot_addr_i),
        .axi_araddr_o  (axi_araddr_o),
        .axi_arvalid_o (axi_arvalid_o),
        .axi_arready_i (axi_arready_i),
        .axi_rvalid_i  (axi_rvalid_i),
        .axi_rready_o  (axi_rready_o),
        .axi_rdata_i   (axi_rdata_i),
        .axi_rresp_i   (axi_rresp_i),
        .fetch_valid_o (fetch_valid),
        .fetch_instr_o (fetch_instr),
        .fetch_pc_o    (fetch_pc),
        .fetch_fault_o (fetch_fault),
        .fetch_ack_i   (fetch_ack)
    );

    decode_issue i_decode_issue (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .fetch_valid_i (fetch_valid),
        .fetch_instr_i (fetch_instr),
        .fetch_pc_i    (fetch_pc),
        .fetch_fault_i (fetch_fault),
        .fetch_ack_o   (fetch_ack),
        .wb_en_i       (wb_en),
        .wb_rd_i       (wb_rd),
        .wb_data_i     (wb_data),
        .issue         (issue)
    );

    alu_commit i_alu_commit (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .issue            (issue),
        .wb_en_o          (wb_en),
        .wb_rd_o          (wb_rd),
        .wb_data_o        (wb_data),
        .commit_valid_o   (commit_valid_o),
        .commit_pc_o      (commit_pc_o),
        .commit_rd_o      (commit_rd_o),
        .commit_we_o      (commit_we_o),
        .commit_wdata_o   (commit_wdata_o),
        .commit_illegal_o (commit_illegal_o),
        .commit_fault_o   (commit_fault_o)
    );

endmodule

/* logic/alu_commit.sv */
// ALU, register write-back and the commit registers

`timescale 1ns/10ps

module alu_commit import core_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    issue_if.execute  issue,
    // Write-back, also the bypass source
    output logic      wb_en_o,
    output reg_addr_t wb_rd_o,
    output xlen_t     wb_data_o,
    // Retirement
    output logic      commit_valid_o,
    output addr_t     commit_pc_o,
    output reg_addr_t commit_rd_o,
    output logic      commit_we_o,
    output xlen_t     commit_wdata_o,
    output logic      commit_illegal_o,
    output logic      commit_fault_o
);

    xlen_t      result;
    logic [4:0] shamt;

    // --------------------------------------------------
    // ALU
    // --------------------------------------------------
    assign shamt = issue.operand_b[4:0];

    always_comb begin
        unique case (issue.alu_op)
            ADD:     result = issue.operand_a + issue.operand_b;
            SUB:     result = issue.operand_a - issue.operand_b;
            SLL:     result = issue.operand_a << shamt;
            SLT:     result = xlen_t'($signed(issue.operand_a) < $signed(issue.operand_b));
            SLTU:    result = xlen_t'(issue.operand_a < issue.operand_b);
            XOR:     result = issue.operand_a ^ issue.operand_b;
            SRL:     result = issue.operand_a >> shamt;
            SRA:     result = xlen_t'($signed(issue.operand_a) >>> shamt);
            OR:      result = issue.operand_a | issue.operand_b;
            AND:     result = issue.operand_a & issue.operand_b;
            default: result = issue.operand_b;
        endcase
    end

    // No architectural effect for illegal, faulted or x0 targets
    assign wb_en_o   = issue.valid && !issue.illegal && !issue.fault && (issue.rd != '0);
    assign wb_rd_o   = issue.rd;
    assign wb_data_o = result;

    // --------------------------------------------------
    // Commit registers
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            commit_valid_o   <= 1'b0;
            commit_we_o      <= 1'b0;
            commit_illegal_o <= 1'b0;
            commit_fault_o   <= 1'b0;
        end else begin
            commit_valid_o   <= issue.valid;
            commit_we_o      <= wb_en_o;
            commit_illegal_o <= issue.valid && issue.illegal;
            commit_fault_o   <= issue.valid && issue.fault;
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue.valid) begin
            commit_pc_o    <= issue.pc;
            commit_rd_o    <= issue.rd;
            commit_wdata_o <= result;
        end
    end

    // A flagged retirement never reports a register write
    flagged_no_we_a : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        commit_valid_o && (commit_illegal_o || commit_fault_o) |-> !commit_we_o
    );

endmodule

/* logic/decode_issue.sv */
// Decoder for the ALU group and LUI, register file with bypass
// and the issue register feeding execute

`timescale 1ns/10ps

`include "core_macros.svh"

module decode_issue import core_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    // Fetch buffer
    input  logic      fetch_valid_i,
    input  instr_t    fetch_instr_i,
    input  addr_t     fetch_pc_i,
    input  logic      fetch_fault_i,
    output logic      fetch_ack_o,
    // Write-back from commit
    input  logic      wb_en_i,
    input  reg_addr_t wb_rd_i,
    input  xlen_t     wb_data_i,
    issue_if.decode   issue
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    xlen_t      imm_i;
    xlen_t      imm_u;
    xlen_t      rs1_val;
    xlen_t      rs2_val;
    xlen_t      op_b;
    alu_op_t    alu_op;
    logic       illegal;

    xlen_t      rf_q [`NR_REGS];

    // Execute never stalls, so a buffered instruction is always taken
    assign fetch_ack_o = fetch_valid_i;

    // --------------------------------------------------
    // Field extraction
    // --------------------------------------------------
    assign opcode = fetch_instr_i[6:0];
    assign rd     = fetch_instr_i[11:7];
    assign funct3 = fetch_instr_i[14:12];
    assign rs1    = fetch_instr_i[19:15];
    assign rs2    = fetch_instr_i[24:20];
    assign funct7 = fetch_instr_i[31:25];

    assign imm_i = {{(`XLEN-12){fetch_instr_i[31]}}, fetch_instr_i[31:20]};
    assign imm_u = {fetch_instr_i[31:12], 12'b0};

    // Register read, x0 reads zero, same-cycle write-back wins
    always_comb begin
        rs1_val = rf_q[rs1];
        if (rs1 == '0) begin
            rs1_val = '0;
        end else if (wb_en_i && (wb_rd_i == rs1)) begin
            rs1_val = wb_data_i;
        end
        rs2_val = rf_q[rs2];
        if (rs2 == '0) begin
            rs2_val = '0;
        end else if (wb_en_i && (wb_rd_i == rs2)) begin
            rs2_val = wb_data_i;
        end
    end

    // --------------------------------------------------
    // Operation and operand selection
    // --------------------------------------------------
    always_comb begin
        illegal = 1'b0;
        op_b    = rs2_val;
        unique case (funct3)
            // SUB only exists in the register form
            `F3_ADD_SUB: alu_op = (opcode == `OPC_OP && funct7 == `F7_ALT) ? SUB : ADD;
            `F3_SLL:     alu_op = SLL;
            `F3_SLT:     alu_op = SLT;
            `F3_SLTU:    alu_op = SLTU;
            `F3_XOR:     alu_op = XOR;
            `F3_SRL_SRA: alu_op = (funct7 == `F7_ALT) ? SRA : SRL;
            `F3_OR:      alu_op = OR;
            `F3_AND:     alu_op = AND;
            default:     alu_op = ADD;
        endcase
        unique case (opcode)
            `OPC_OP:     op_b = rs2_val;
            `OPC_OP_IMM: op_b = imm_i;
            `OPC_LUI: begin
                alu_op = PASS_B;
                op_b   = imm_u;
            end
            default:     illegal = 1'b1;
        endcase
    end

    // --------------------------------------------------
    // Register file and issue register
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (wb_en_i && (wb_rd_i != '0)) begin
            rf_q[wb_rd_i] <= wb_data_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            issue.valid <= 1'b0;
        end else begin
            issue.valid <= fetch_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fetch_valid_i) begin
            issue.alu_op    <= alu_op;
            issue.rd        <= rd;
            issue.operand_a <= rs1_val;
            issue.operand_b <= op_b;
            // Fault takes precedence, the fetched word is not meaningful
            issue.illegal   <= illegal && !fetch_fault_i;
            issue.fault     <= fetch_fault_i;
            issue.pc        <= fetch_pc_i;
        end
    end

    // Commit never requests a write to x0
    x0_no_write_a : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        wb_en_i |-> (wb_rd_i != '0)
    );

endmodule

/* logic/fetch_unit.sv */
// PC generation, AXI4-Lite read master and one-entry fetch buffer

`timescale 1ns/10ps

`include "core_macros.svh"

module fetch_unit import core_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      fetch_en_i,
    input  addr_t     boot_addr_i,
    // AXI4-Lite read channels
    output addr_t     axi_araddr_o,
    output logic      axi_arvalid_o,
    input  logic      axi_arready_i,
    input  logic      axi_rvalid_i,
    output logic      axi_rready_o,
    input  xlen_t     axi_rdata_i,
    input  axi_resp_t axi_rresp_i,
    // Fetch buffer towards decode
    output logic      fetch_valid_o,
    output instr_t    fetch_instr_o,
    output addr_t     fetch_pc_o,
    output logic      fetch_fault_o,
    input  logic      fetch_ack_i
);

    fetch_state_t state_q, state_d;
    addr_t        pc_q;
    addr_t        req_pc_q;
    logic         ar_hs;
    logic         r_hs;

    logic         buf_valid_q;
    instr_t       buf_instr_q;
    addr_t        buf_pc_q;
    logic         buf_fault_q;

    // --------------------------------------------------
    // Read handshakes
    // --------------------------------------------------
    assign axi_araddr_o  = pc_q;
    assign axi_arvalid_o = (state_q == ADDR);
    // Accept data only when the buffer drains in the same cycle
    assign axi_rready_o  = (state_q == DATA) && (!buf_valid_q || fetch_ack_i);

    assign ar_hs = axi_arvalid_o && axi_arready_i;
    assign r_hs  = axi_rvalid_i && axi_rready_o;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: if (fetch_en_i) state_d = ADDR;
            ADDR: if (ar_hs) state_d = DATA;
            // Next request goes out one cycle after the data returns
            DATA: if (r_hs) state_d = fetch_en_i ? ADDR : IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= IDLE;
            pc_q        <= boot_addr_i;
            buf_valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (ar_hs) begin
                pc_q <= pc_q + addr_t'(4);
            end
            if (r_hs) begin
                buf_valid_q <= 1'b1;
            end else if (fetch_ack_i) begin
                buf_valid_q <= 1'b0;
            end
        end
    end

    // PC of the read in flight, then the buffered instruction
    always_ff @(posedge clk_i) begin
        if (ar_hs) begin
            req_pc_q <= pc_q;
        end
        if (r_hs) begin
            buf_instr_q <= axi_rdata_i;
            buf_pc_q    <= req_pc_q;
            buf_fault_q <= (axi_rresp_i != `AXI_RESP_OKAY);
        end
    end

    assign fetch_valid_o = buf_valid_q;
    assign fetch_instr_o = buf_instr_q;
    assign fetch_pc_o    = buf_pc_q;
    assign fetch_fault_o = buf_fault_q;

    // AR request is held with a stable address until accepted
    ar_hold_a : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        axi_arvalid_o && !axi_arready_i |=> axi_arvalid_o && $stable(axi_araddr_o)
    );

endmodule

/* logic/issue_if.sv */
// Decoded instruction handed from decode to execute

`timescale 1ns/10ps

interface issue_if import core_pkg::*; ();

    logic      valid;
    alu_op_t   alu_op;
    reg_addr_t rd;
    xlen_t     operand_a;
    xlen_t     operand_b;
    logic      illegal;
    logic      fault;
    addr_t     pc;

    // Decode fills the issue register
    modport decode (
        output valid, alu_op, rd, operand_a, operand_b, illegal, fault, pc
    );

    // Execute is always ready, it consumes whatever is valid
    modport execute (
        input valid, alu_op, rd, operand_a, operand_b, illegal, fault, pc
    );

endinterface

/* logic/core_pkg.sv */
// Shared types of the core
// Data words, addresses, register indices, ALU operations, fetch FSM states

`include "core_macros.svh"

package core_pkg;

    // --------------------------------------------------
    // Plain vector types
    // --------------------------------------------------
    typedef logic [`XLEN-1:0] xlen_t;
    typedef logic [`XLEN-1:0] addr_t;
    typedef logic [31:0]      instr_t;

    // Index into the architectural register file
    typedef logic [$clog2(`NR_REGS)-1:0] reg_addr_t;

    // AXI4-Lite response field
    typedef logic [1:0] axi_resp_t;

    // --------------------------------------------------
    // Enumerations
    // --------------------------------------------------
    // ALU operations, PASS_B forwards operand b for LUI
    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        PASS_B
    } alu_op_t;

    // Fetch sequencing, address phase then data phase
    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA
    } fetch_state_t;

endpackage

/* include/core_macros.svh */
// Core widths, RV32I opcode and funct encodings
// AXI4-Lite response code used by the fetch port

`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Data path and register file
`define XLEN    32
`define NR_REGS 32

// --------------------------------------------------
// RV32I opcodes of the supported groups
// --------------------------------------------------
`define OPC_OP     7'b0110011
`define OPC_OP_IMM 7'b0010011
`define OPC_LUI    7'b0110111

// funct3 of the ALU group
`define F3_ADD_SUB 3'b000
`define F3_SLL     3'b001
`define F3_SLT     3'b010
`define F3_SLTU    3'b011
`define F3_XOR     3'b100
`define F3_SRL_SRA 3'b101
`define F3_OR      3'b110
`define F3_AND     3'b111

// funct7 selecting SUB and SRA
`define F7_ALT 7'b0100000

// AXI read response
`define AXI_RESP_OKAY 2'b00

`endif
